// File: Bender.yml
package:
  name: des_round

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/desRoundPkg.sv
      - hw/desExpandMix.sv
      - hw/desSubstitute.sv
      - hw/desRoundFunc.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/desRoundChecker.sv
      - verification/desRoundTb.sv

// File: hw/desExpandMix.sv
`timescale 1ns/1ps
`include "desRound_settings.svh"

module desExpandMix
    import desRoundPkg::*;
(
    input  logic       clk,
    input  logic       rstN,

    input  logic       inValid,
    output logic       inReady,
    input  roundReq_t  inReq,

    output logic       mixValid,
    input  logic       mixReady,
    output mixedWord_t mixWord
);

    roundKey_t  expanded;
    mixedWord_t mixNext;

    // E expansion, table counts bits from the MSB
    always_comb
    begin
        for (int i = 0; i < `DES_KEY_WIDTH; i++)
        begin
            expanded[`DES_KEY_WIDTH-1-i] = inReq.data[`DES_HALF_WIDTH-1-EXPANSION_TABLE[i]];
        end
    end

    // Key mix, chunk by chunk
    always_comb
    begin
        for (int c = 0; c < `DES_SBOX_COUNT; c++)
        begin
            mixNext[c].raw = expanded[c*`DES_CHUNK_WIDTH +: `DES_CHUNK_WIDTH]
                           ^ inReq.key[c*`DES_CHUNK_WIDTH +: `DES_CHUNK_WIDTH];
        end
    end

    // Free slot, or the slot drains this cycle
    assign inReady = !mixValid || mixReady;

    always_ff @(posedge clk)
    begin
        if (!rstN)
            mixValid <= 1'b0;
        else if (inReady)
            mixValid <= inValid;
    end

    always_ff @(posedge clk)
    begin
        if (inValid && inReady)
            mixWord <= mixNext;
    end

endmodule

// File: hw/desRoundFunc.sv
`timescale 1ns/1ps

module desRoundFunc
    import desRoundPkg::*;
(
    input  logic      clk,
    input  logic      rstN,

    input  logic      inValid,
    output logic      inReady,
    input  roundReq_t inReq,

    output logic      outValid,
    input  logic      outReady,
    output halfBlock_t outData
);

    logic       mixValid;
    logic       mixReady;
    mixedWord_t mixWord;

    desExpandMix i_expandMix (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inReq    (inReq),
        .mixValid (mixValid),
        .mixReady (mixReady),
        .mixWord  (mixWord)
    );

    desSubstitute i_substitute (
        .clk      (clk),
        .rstN     (rstN),
        .mixValid (mixValid),
        .mixReady (mixReady),
        .mixWord  (mixWord),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outData)
    );

endmodule

// File: hw/desRoundPkg.sv
`include "desRound_settings.svh"

package desRoundPkg;

    ////////////////////////////////////////
    // Data types
    ////////////////////////////////////////

    typedef logic [`DES_HALF_WIDTH-1:0] halfBlock_t;
    typedef logic [`DES_KEY_WIDTH-1:0] roundKey_t;

    typedef struct packed {
        halfBlock_t data;
        roundKey_t  key;
    } roundReq_t;

    // Row is {outerHi, outerLo}
    typedef struct packed {
        logic                         outerHi;
        logic [`DES_CHUNK_WIDTH-3:0] column;
        logic                         outerLo;
    } sboxAddr_t;

    typedef union packed {
        logic [`DES_CHUNK_WIDTH-1:0] raw;
        sboxAddr_t                   addr;
    } sboxChunk_t;

    // Chunk 7 is the MSB chunk and feeds S-box 1
    typedef sboxChunk_t [`DES_SBOX_COUNT-1:0] mixedWord_t;

    ////////////////////////////////////////
    // Tables
    ////////////////////////////////////////

    // Source bit per output bit, counted from the MSB
    localparam int EXPANSION_TABLE [`DES_KEY_WIDTH] = '{
        31,  0,  1,  2,  3,  4,
         3,  4,  5,  6,  7,  8,
         7,  8,  9, 10, 11, 12,
        11, 12, 13, 14, 15, 16,
        15, 16, 17, 18, 19, 20,
        19, 20, 21, 22, 23, 24,
        23, 24, 25, 26, 27, 28,
        27, 28, 29, 30, 31,  0
    };

    localparam int PERMUTATION_TABLE [`DES_HALF_WIDTH] = '{
        15,  6, 19, 20, 28, 11, 27, 16,
         0, 14, 22, 25,  4, 17, 30,  9,
         1,  7, 23, 13, 31, 26,  2,  8,
        18, 12, 29,  5, 21, 10,  3, 24
    };

    // Indexed [box][row][column], box 0 is S-box 1
    localparam logic [`DES_NIBBLE_WIDTH-1:0] SBOX_TABLE [`DES_SBOX_COUNT][4][16] = '{
        '{
            '{14,  4, 13,  1,  2, 15, 11,  8,  3, 10,  6, 12,  5,  9,  0,  7},
            '{ 0, 15,  7,  4, 14,  2, 13,  1, 10,  6, 12, 11,  9,  5,  3,  8},
            '{ 4,  1, 14,  8, 13,  6,  2, 11, 15, 12,  9,  7,  3, 10,  5,  0},
            '{15, 12,  8,  2,  4,  9,  1,  7,  5, 11,  3, 14, 10,  0,  6, 13}
        },
        '{
            '{15,  1,  8, 14,  6, 11,  3,  4,  9,  7,  2, 13, 12,  0,  5, 10},
            '{ 3, 13,  4,  7, 15,  2,  8, 14, 12,  0,  1, 10,  6,  9, 11,  5},
            '{ 0, 14,  7, 11, 10,  4, 13,  1,  5,  8, 12,  6,  9,  3,  2, 15},
            '{13,  8, 10,  1,  3, 15,  4,  2, 11,  6,  7, 12,  0,  5, 14,  9}
        },
        '{
            '{10,  0,  9, 14,  6,  3, 15,  5,  1, 13, 12,  7, 11,  4,  2,  8},
            '{13,  7,  0,  9,  3,  4,  6, 10,  2,  8,  5, 14, 12, 11, 15,  1},
            '{13,  6,  4,  9,  8, 15,  3,  0, 11,  1,  2, 12,  5, 10, 14,  7},
            '{ 1, 10, 13,  0,  6,  9,  8,  7,  4, 15, 14,  3, 11,  5,  2, 12}
        },
        '{
            '{ 7, 13, 14,  3,  0,  6,  9, 10,  1,  2,  8,  5, 11, 12,  4, 15},
            '{13,  8, 11,  5,  6, 15,  0,  3,  4,  7,  2, 12,  1, 10, 14,  9},
            '{10,  6,  9,  0, 12, 11,  7, 13, 15,  1,  3, 14,  5,  2,  8,  4},
            '{ 3, 15,  0,  6, 10,  1, 13,  8,  9,  4,  5, 11, 12,  7,  2, 14}
        },
        '{
            '{ 2, 12,  4,  1,  7, 10, 11,  6,  8,  5,  3, 15, 13,  0, 14,  9},
            '{14, 11,  2, 12,  4,  7, 13,  1,  5,  0, 15, 10,  3,  9,  8,  6},
            '{ 4,  2,  1, 11, 10, 13,  7,  8, 15,  9, 12,  5,  6,  3,  0, 14},
            '{11,  8, 12,  7,  1, 14,  2, 13,  6, 15,  0,  9, 10,  4,  5,  3}
        },
        '{
            '{12,  1, 10, 15,  9,  2,  6,  8,  0, 13,  3,  4, 14,  7,  5, 11},
            '{10, 15,  4,  2,  7, 12,  9,  5,  6,  1, 13, 14,  0, 11,  3,  8},
            '{ 9, 14, 15,  5,  2,  8, 12,  3,  7,  0,  4, 10,  1, 13, 11,  6},
            '{ 4,  3,  2, 12,  9,  5, 15, 10, 11, 14,  1,  7,  6,  0,  8, 13}
        },
        '{
            '{ 4, 11,  2, 14, 15,  0,  8, 13,  3, 12,  9,  7,  5, 10,  6,  1},
            '{13,  0, 11,  7,  4,  9,  1, 10, 14,  3,  5, 12,  2, 15,  8,  6},
            '{ 1,  4, 11, 13, 12,  3,  7, 14, 10, 15,  6,  8,  0,  5,  9,  2},
            '{ 6, 11, 13,  8,  1,  4, 10,  7,  9,  5,  0, 15, 14,  2,  3, 12}
        },
        '{
            '{13,  2,  8,  4,  6, 15, 11,  1, 10,  9,  3, 14,  5,  0, 12,  7},
            '{ 1, 15, 13,  8, 10,  3,  7,  4, 12,  5,  6, 11,  0, 14,  9,  2},
            '{ 7, 11,  4,  1,  9, 12, 14,  2,  0,  6, 10, 13, 15,  3,  5,  8},
            '{ 2,  1, 14,  7,  4, 10,  8, 13, 15, 12,  9,  0,  3,  5,  6, 11}
        }
    };

endpackage

// File: hw/desSubstitute.sv
`timescale 1ns/1ps
`include "desRound_settings.svh"

module desSubstitute
    import desRoundPkg::*;
(
    input  logic       clk,
    input  logic       rstN,

    input  logic       mixValid,
    output logic       mixReady,
    input  mixedWord_t mixWord,

    output logic       outValid,
    input  logic       outReady,
    output halfBlock_t outData
);

    halfBlock_t sboxOut;
    halfBlock_t permuted;

    // Chunk c goes to S-box 8-c, nibble lands in the same slot
    always_comb
    begin
        for (int c = 0; c < `DES_SBOX_COUNT; c++)
        begin
            sboxOut[c*`DES_NIBBLE_WIDTH +: `DES_NIBBLE_WIDTH] =
                SBOX_TABLE[`DES_SBOX_COUNT-1-c]
                          [{mixWord[c].addr.outerHi, mixWord[c].addr.outerLo}]
                          [mixWord[c].addr.column];
        end
    end

    // P permutation
    always_comb
    begin
        for (int i = 0; i < `DES_HALF_WIDTH; i++)
        begin
            permuted[`DES_HALF_WIDTH-1-i] = sboxOut[`DES_HALF_WIDTH-1-PERMUTATION_TABLE[i]];
        end
    end

    assign mixReady = !outValid || outReady;

    always_ff @(posedge clk)
    begin
        if (!rstN)
            outValid <= 1'b0;
        else if (mixReady)
            outValid <= mixValid;
    end

    always_ff @(posedge clk)
    begin
        if (mixValid && mixReady)
            outData <= permuted;
    end

endmodule

// File: include/desRound_settings.svh
`ifndef DESROUND_SETTINGS_SVH
`define DESROUND_SETTINGS_SVH

// Half-block, data input and f-function output
`define DES_HALF_WIDTH 32

// Round key and expanded word
`define DES_KEY_WIDTH 48

// One S-box input
`define DES_CHUNK_WIDTH 6

// One S-box output
`define DES_NIBBLE_WIDTH 4

`define DES_SBOX_COUNT 8

`endif

// File: verification/desRoundChecker.sv
`timescale 1ns/1ps

module desRoundChecker
    import desRoundPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic       inValid,
    input  logic       inReady,
    input  roundReq_t  inReq,
    input  logic       outValid,
    input  logic       outReady,
    input  halfBlock_t outData,
    input  logic       checkLatency,
    output int         pending,
    output int         errors,
    output halfBlock_t lastOut
);

    ////////////////////////////////////////
    // Reference tables
    ////////////////////////////////////////

    // One S-box per entry with rows 0..3 from the top and column 0 in the top nibble
    localparam logic [255:0] SBOX_ROWS [8] = '{
        256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
        256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
        256'hA09E63F51DC7B428_D709346A285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
        256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
        256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
        256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
        256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
        256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B
    };

    // P table in the usual 1-based notation
    localparam int P_ONE_BASED [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
    };

    halfBlock_t expQ[$];
    int         cycQ[$];
    int         errCount = 0;
    int         cycle = 0;
    int         resetEdges = 0;
    logic       rstPrev = 1'b1;
    logic       holding = 1'b0;
    halfBlock_t heldData = '0;
    halfBlock_t lastSeen = '0;
    halfBlock_t expected;
    int         inCycle;

    assign errors  = errCount;
    assign lastOut = lastSeen;

    function automatic halfBlock_t fModel(input halfBlock_t r, input roundKey_t k);
        roundKey_t  x;
        halfBlock_t s;
        halfBlock_t f;
        logic [5:0] chunk;
        int         src;
        int         idx;
        // E groups overlap by one bit on each side and wrap around
        for (int i = 0; i < 48; i++)
        begin
            src = (4 * (i / 6) + i % 6 + 31) % 32;
            x[47 - i] = r[31 - src] ^ k[47 - i];
        end
        for (int b = 0; b < 8; b++)
        begin
            chunk = x[47 - 6 * b -: 6];
            idx = ({chunk[5], chunk[0]} * 16 + chunk[4:1]) * 4;
            s[31 - 4 * b -: 4] = SBOX_ROWS[b][255 - idx -: 4];
        end
        for (int i = 0; i < 32; i++)
            f[31 - i] = s[32 - P_ONE_BASED[i]];
        return f;
    endfunction

    always @(posedge clk)
    begin
        // Reset values are only known after the first reset edge
        if (resetEdges > 0 && (!rstN || !rstPrev))
        begin
            if (outValid !== 1'b0)
            begin
                $display("[FAIL] %0t outValid expected 0 actual %b", $time, outValid);
                errCount++;
            end
            if (inReady !== 1'b1)
            begin
                $display("[FAIL] %0t inReady expected 1 actual %b", $time, inReady);
                errCount++;
            end
        end
        if (!rstN)
        begin
            resetEdges++;
            expQ.delete();
            cycQ.delete();
            holding = 1'b0;
        end
        else
        begin
            if (holding && outValid !== 1'b1)
            begin
                $display("Error at %0t: outValid dropped before the result was taken", $time);
                errCount++;
            end
            else if (holding && outData !== heldData)
            begin
                $display("[FAIL] %0t outData expected %h actual %h", $time, heldData, outData);
                errCount++;
            end
            if (inValid && inReady)
            begin
                expQ.push_back(fModel(inReq.data, inReq.key));
                cycQ.push_back(cycle);
            end
            if (outValid && outReady)
            begin
                if (expQ.size() == 0)
                begin
                    $display("Error at %0t: result delivered with no request pending", $time);
                    errCount++;
                end
                else
                begin
                    expected = expQ.pop_front();
                    inCycle = cycQ.pop_front();
                    if (outData !== expected)
                    begin
                        $display("[FAIL] %0t outData expected %h actual %h",
                                 $time, expected, outData);
                        errCount++;
                    end
                    if (checkLatency && cycle - inCycle != 2)
                    begin
                        $display("Error at %0t: result came %0d cycles after its request, not 2",
                                 $time, cycle - inCycle);
                        errCount++;
                    end
                    lastSeen = outData;
                end
            end
            holding = outValid && !outReady;
            heldData = outData;
        end
        pending = expQ.size();
        rstPrev = rstN;
        cycle++;
    end

endmodule

// File: verification/desRoundTb.sv
`timescale 1ns/1ps

module desRoundTb
    import desRoundPkg::*;
();

    localparam int FULL_RATE_ITEMS = 200;
    localparam int BACK_PRESSURE_ITEMS = 300;
    localparam int EDGE_ITEMS = 34;
    localparam int TOTAL_ITEMS = 1 + FULL_RATE_ITEMS + BACK_PRESSURE_ITEMS + EDGE_ITEMS;
    localparam int CYCLE_LIMIT = 4 * TOTAL_ITEMS + 100;

    logic       clk;
    logic       rstN;
    logic       inValid;
    logic       inReady;
    roundReq_t  inReq;
    logic       outValid;
    logic       outReady;
    halfBlock_t outData;

    logic       checkLatency;
    logic       backPressure;
    int         pending;
    int         checkErrors;
    halfBlock_t lastOut;

    int         seed = 32'h22e0_9a57;
    int         cycles = 0;
    int         stalls = 0;
    int         tbErrors = 0;
    int         errMark = 0;
    int         testsPassed = 0;
    int         testsFailed = 0;
    roundReq_t  req;

    desRoundFunc i_dut (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inReq    (inReq),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outData)
    );

    desRoundChecker i_checker (
        .clk          (clk),
        .rstN         (rstN),
        .inValid      (inValid),
        .inReady      (inReady),
        .inReq        (inReq),
        .outValid     (outValid),
        .outReady     (outReady),
        .outData      (outData),
        .checkLatency (checkLatency),
        .pending      (pending),
        .errors       (checkErrors),
        .lastOut      (lastOut)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    task automatic driveReady();
        if (backPressure)
            outReady = ($random(seed) % 2) != 0;
        else
            outReady = 1'b1;
    endtask

    task automatic makeRandomReq(output roundReq_t r);
        logic [31:0] hi;
        logic [31:0] lo;
        r.data = $random(seed);
        hi = $random(seed);
        lo = $random(seed);
        r.key = {hi[15:0], lo};
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic sendItem(input roundReq_t r);
        logic accepted;
        accepted = 1'b0;
        while (backPressure && ($random(seed) % 4) == 0)
        begin
            inValid = 1'b0;
            driveReady();
            @(posedge clk);
            @(negedge clk);
        end
        inValid = 1'b1;
        inReq = r;
        driveReady();
        @(posedge clk);
        accepted = inReady;
        @(negedge clk);
        while (!accepted)
        begin
            stalls++;
            driveReady();
            @(posedge clk);
            accepted = inReady;
            @(negedge clk);
        end
        inValid = 1'b0;
    endtask

    task automatic drain();
        inValid = 1'b0;
        outReady = 1'b1;
        while (pending != 0)
            @(negedge clk);
    endtask

    task automatic finishTest(input string name);
        int newErrors;
        newErrors = checkErrors + tbErrors - errMark;
        errMark = checkErrors + tbErrors;
        if (newErrors == 0)
        begin
            $display("Test %s: PASS", name);
            testsPassed++;
        end
        else
        begin
            $display("Test %s: FAIL with %0d errors", name, newErrors);
            testsFailed++;
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        rstN = 1'b0;
        inValid = 1'b0;
        inReq = '0;
        outReady = 1'b1;
        checkLatency = 1'b0;
        backPressure = 1'b0;
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        finishTest("reset state");

        // Textbook first round
        req.data = 32'hF0AAF0AA;
        req.key = 48'h1B02EFFC7072;
        sendItem(req);
        drain();
        if (lastOut !== 32'h234AA9BB)
        begin
            $display("[FAIL] %0t outData expected 234aa9bb actual %h", $time, lastOut);
            tbErrors++;
        end
        finishTest("known answer");

        checkLatency = 1'b1;
        stalls = 0;
        repeat (FULL_RATE_ITEMS)
        begin
            makeRandomReq(req);
            sendItem(req);
        end
        drain();
        checkLatency = 1'b0;
        if (stalls != 0)
        begin
            $display("Error: input stalled %0d times with outReady held high", stalls);
            tbErrors++;
        end
        finishTest("full rate");

        backPressure = 1'b1;
        repeat (BACK_PRESSURE_ITEMS)
        begin
            makeRandomReq(req);
            sendItem(req);
        end
        backPressure = 1'b0;
        drain();
        finishTest("back-pressure");

        req = '0;
        sendItem(req);
        req = '1;
        sendItem(req);
        for (int b = 0; b < 32; b++)
        begin
            req.data = 32'h1 << b;
            req.key = '0;
            sendItem(req);
        end
        drain();
        finishTest("edge operands");

        $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+include
hw/desRoundPkg.sv
hw/desExpandMix.sv
hw/desSubstitute.sv
hw/desRoundFunc.sv
verification/desRoundChecker.sv
verification/desRoundTb.sv
